/* hdl/div_pkg.sv */
package div_pkg;

    // datapath width
    localparam int unsigned XLEN = 32;

    // register index and commit tag widths
    localparam int unsigned REG_ADDR_W  = 5;
    localparam int unsigned COMMIT_ID_W = 3;

    // one-hot op vector layout
    localparam int unsigned OP_W    = 4;
    localparam int unsigned OP_DIV  = 0;
    localparam int unsigned OP_DIVU = 1;
    localparam int unsigned OP_REM  = 2;
    localparam int unsigned OP_REMU = 3;

    // start to valid, in cycles
    localparam int unsigned DIV_CYCLES = 34;

    // shift-subtract steps, one extra CALC cycle finalizes the result
    localparam int unsigned DIV_ITERS = DIV_CYCLES - 2;
    localparam int unsigned CNT_W     = $clog2(DIV_ITERS + 1);

    typedef logic [XLEN-1:0]        data_t;
    typedef logic [REG_ADDR_W-1:0]  reg_addr_t;
    typedef logic [COMMIT_ID_W-1:0] commit_id_t;
    typedef logic [OP_W-1:0]        div_op_t;

    // divider sequencing
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        CALC = 2'd1,
        DONE = 2'd2
    } div_state_e;

endpackage

/* hdl/div_iter.sv */
module div_iter (
    input  logic             clk,
    input  logic             rst_n,
    input  div_pkg::data_t   dividend_i,
    input  div_pkg::data_t   divisor_i,
    input  div_pkg::div_op_t op_i,
    input  logic             start_i,
    input  logic             ctrl_ready_i,
    output div_pkg::data_t   result_o,
    output logic             busy_o,
    output logic             valid_o
);

    import div_pkg::*;

    div_state_e       state_q;
    logic [CNT_W-1:0] cnt_q;

    // operand conditioning at start
    logic  op_signed;
    logic  a_neg;
    logic  b_neg;
    data_t a_abs;
    data_t b_abs;
    logic  div_zero_d;
    logic  ovf_d;
    logic  start_ok;

    // working registers
    data_t   quo_q;
    data_t   rem_q;
    data_t   dvs_q;
    data_t   dend_q;
    div_op_t op_q;
    logic    neg_quo_q;
    logic    neg_rem_q;
    logic    zero_q;
    logic    ovf_q;
    data_t   result_q;

    // one restoring step
    logic [XLEN:0] rem_sh;
    logic [XLEN:0] diff;

    // final result selection
    logic  is_quo;
    data_t quo_fix;
    data_t rem_fix;
    data_t final_res;

    assign op_signed  = op_i[OP_DIV] | op_i[OP_REM];
    assign a_neg      = op_signed & dividend_i[XLEN-1];
    assign b_neg      = op_signed & divisor_i[XLEN-1];
    assign a_abs      = a_neg ? data_t'(-dividend_i) : dividend_i;
    assign b_abs      = b_neg ? data_t'(-divisor_i) : divisor_i;
    assign div_zero_d = (divisor_i == '0);
    assign ovf_d      = op_signed && (dividend_i == {1'b1, {(XLEN - 1){1'b0}}})
                        && (divisor_i == '1);
    assign start_ok   = (state_q == IDLE) && start_i;

    assign rem_sh = {rem_q, quo_q[XLEN-1]};
    assign diff   = rem_sh - {1'b0, dvs_q};

    assign is_quo  = op_q[OP_DIV] | op_q[OP_DIVU];
    assign quo_fix = neg_quo_q ? data_t'(-quo_q) : quo_q;
    assign rem_fix = neg_rem_q ? data_t'(-rem_q) : rem_q;

    // RISC-V corner cases override the iterated result
    always_comb begin
        if (zero_q) begin
            final_res = is_quo ? '1 : dend_q;
        end else if (ovf_q) begin
            final_res = is_quo ? dend_q : '0;
        end else begin
            final_res = is_quo ? quo_fix : rem_fix;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (start_i) begin
                        state_q <= CALC;
                        cnt_q   <= '0;
                    end
                end
                CALC: begin
                    if (cnt_q == CNT_W'(DIV_ITERS)) begin
                        state_q <= DONE;
                    end else begin
                        cnt_q <= cnt_q + 1'b1;
                    end
                end
                DONE: begin
                    // hold until write-back takes the result
                    if (ctrl_ready_i) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start_ok) begin
            quo_q     <= a_abs;
            rem_q     <= '0;
            dvs_q     <= b_abs;
            dend_q    <= dividend_i;
            op_q      <= op_i;
            neg_quo_q <= a_neg ^ b_neg;
            neg_rem_q <= a_neg;
            zero_q    <= div_zero_d;
            ovf_q     <= ovf_d;
        end else if (state_q == CALC) begin
            if (cnt_q != CNT_W'(DIV_ITERS)) begin
                // no borrow means the divisor fits
                if (!diff[XLEN]) begin
                    rem_q <= diff[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b1};
                end else begin
                    rem_q <= rem_sh[XLEN-1:0];
                    quo_q <= {quo_q[XLEN-2:0], 1'b0};
                end
            end else begin
                result_q <= final_res;
            end
        end
    end

    assign result_o = result_q;
    assign busy_o   = (state_q == CALC);
    assign valid_o  = (state_q == DONE);

endmodule

/* hdl/div_issue_buf.sv */
module div_issue_buf (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_div_i,
    input  logic                int_assert_i,
    input  div_pkg::reg_addr_t  reg_waddr_i,
    input  div_pkg::commit_id_t commit_id_i,
    input  div_pkg::div_op_t    op_i,
    input  div_pkg::data_t      reg1_rdata_i,
    input  div_pkg::data_t      reg2_rdata_i,
    input  div_pkg::data_t      alu1_bypass_i,
    input  div_pkg::data_t      alu2_bypass_i,
    input  logic                pass_alu1_op1_i,
    input  logic                pass_alu2_op1_i,
    input  logic                pass_alu1_op2_i,
    input  logic                pass_alu2_op2_i,
    input  logic                div0_busy_i,
    input  logic                div0_valid_i,
    input  logic                div1_busy_i,
    input  logic                div1_valid_i,
    output div_pkg::data_t      dividend_o,
    output div_pkg::data_t      divisor_o,
    output div_pkg::div_op_t    op_o,
    output div_pkg::reg_addr_t  waddr_o,
    output div_pkg::commit_id_t cid_o,
    output logic                start0_o,
    output logic                start1_o,
    output logic                div_stall_o
);

    import div_pkg::*;

    // resolved live operands
    data_t op1_res;
    data_t op2_res;

    logic req_live;
    logic div0_avail;
    logic div1_avail;
    logic issue_req;
    logic any_start;
    logic buf_load;

    // one-entry request buffer
    logic       buf_valid_q;
    data_t      buf_dividend_q;
    data_t      buf_divisor_q;
    div_op_t    buf_op_q;
    reg_addr_t  buf_waddr_q;
    commit_id_t buf_cid_q;

    // ALU1 bypass wins over ALU2, then the register file
    assign op1_res = pass_alu1_op1_i ? alu1_bypass_i :
                     pass_alu2_op1_i ? alu2_bypass_i : reg1_rdata_i;
    assign op2_res = pass_alu1_op2_i ? alu1_bypass_i :
                     pass_alu2_op2_i ? alu2_bypass_i : reg2_rdata_i;

    // interrupt cancels the live request
    assign req_live = req_div_i && !int_assert_i;

    assign div0_avail = !div0_busy_i && !div0_valid_i;
    assign div1_avail = !div1_busy_i && !div1_valid_i;

    // buffered request goes first
    assign issue_req = buf_valid_q || req_live;
    assign start0_o  = issue_req && div0_avail;
    assign start1_o  = issue_req && !div0_avail && div1_avail;
    assign any_start = start0_o || start1_o;

    assign buf_load = !buf_valid_q && req_live && !div0_avail && !div1_avail;

    assign dividend_o = buf_valid_q ? buf_dividend_q : op1_res;
    assign divisor_o  = buf_valid_q ? buf_divisor_q : op2_res;
    assign op_o       = buf_valid_q ? buf_op_q : op_i;
    assign waddr_o    = buf_valid_q ? buf_waddr_q : reg_waddr_i;
    assign cid_o      = buf_valid_q ? buf_cid_q : commit_id_i;

    // source holds its request while the buffer is occupied
    assign div_stall_o = buf_valid_q && req_live;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buf_valid_q <= 1'b0;
        end else if (buf_load) begin
            buf_valid_q <= 1'b1;
        end else if (buf_valid_q && any_start) begin
            buf_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (buf_load) begin
            buf_dividend_q <= op1_res;
            buf_divisor_q  <= op2_res;
            buf_op_q       <= op_i;
            buf_waddr_q    <= reg_waddr_i;
            buf_cid_q      <= commit_id_i;
        end
    end

endmodule

/* hdl/div_wb_ctrl.sv */
module div_wb_ctrl (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                start0_i,
    input  logic                start1_i,
    input  div_pkg::reg_addr_t  waddr_i,
    input  div_pkg::commit_id_t cid_i,
    input  logic                div0_valid_i,
    input  logic                div1_valid_i,
    input  logic                div0_busy_i,
    input  logic                div1_busy_i,
    input  div_pkg::data_t      div0_result_i,
    input  div_pkg::data_t      div1_result_i,
    input  logic                wb_ready_i,
    output logic                ready0_o,
    output logic                ready1_o,
    output logic                reg_we_o,
    output div_pkg::reg_addr_t  reg_waddr_o,
    output div_pkg::data_t      reg_wdata_o,
    output div_pkg::commit_id_t commit_id_o
);

    import div_pkg::*;

    // per-divider tags
    reg_addr_t  tag0_waddr_q;
    reg_addr_t  tag1_waddr_q;
    commit_id_t tag0_cid_q;
    commit_id_t tag1_cid_q;

    // write-after-write marks
    logic mark0_q;
    logic mark1_q;

    logic occ0;
    logic occ1;
    logic sel0;
    logic sel1;
    logic grant0;
    logic grant1;
    logic accept0;
    logic accept1;

    // a presented result not yet taken keeps its slot
    logic hold_q;
    logic hold_sel1_q;

    assign occ0 = div0_busy_i || div0_valid_i;
    assign occ1 = div1_busy_i || div1_valid_i;

    assign sel0 = div0_valid_i && !mark0_q;
    assign sel1 = div1_valid_i && !mark1_q;

    // div0 first unless div1 is already on the port
    assign grant1 = sel1 && (hold_q ? hold_sel1_q : !sel0);
    assign grant0 = sel0 && !grant1;

    assign accept0 = grant0 && wb_ready_i;
    assign accept1 = grant1 && wb_ready_i;

    assign ready0_o = accept0;
    assign ready1_o = accept1;

    always_ff @(posedge clk) begin
        if (start0_i) begin
            tag0_waddr_q <= waddr_i;
            tag0_cid_q   <= cid_i;
        end
        if (start1_i) begin
            tag1_waddr_q <= waddr_i;
            tag1_cid_q   <= cid_i;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mark0_q     <= 1'b0;
            mark1_q     <= 1'b0;
            hold_q      <= 1'b0;
            hold_sel1_q <= 1'b0;
        end else begin
            // younger write waits while the older one to the same rd is live
            if (start0_i) begin
                mark0_q <= occ1 && !accept1 && (tag1_waddr_q == waddr_i);
            end else if (accept1) begin
                mark0_q <= 1'b0;
            end
            if (start1_i) begin
                mark1_q <= occ0 && !accept0 && (tag0_waddr_q == waddr_i);
            end else if (accept0) begin
                mark1_q <= 1'b0;
            end
            hold_q      <= reg_we_o && !wb_ready_i;
            hold_sel1_q <= grant1;
        end
    end

    assign reg_we_o    = grant0 || grant1;
    assign reg_wdata_o = grant0 ? div0_result_i :
                         grant1 ? div1_result_i : '0;
    assign reg_waddr_o = grant0 ? tag0_waddr_q :
                         grant1 ? tag1_waddr_q : '0;
    assign commit_id_o = grant0 ? tag0_cid_q :
                         grant1 ? tag1_cid_q : '0;

endmodule

/* hdl/exu_div.sv */
module exu_div (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                req_div_i,
    input  div_pkg::reg_addr_t  reg_waddr_i,
    input  div_pkg::commit_id_t commit_id_i,
    input  logic                op_div_i,
    input  logic                op_divu_i,
    input  logic                op_rem_i,
    input  logic                op_remu_i,
    input  div_pkg::data_t      reg1_rdata_i,
    input  div_pkg::data_t      reg2_rdata_i,
    input  div_pkg::data_t      alu1_bypass_i,
    input  div_pkg::data_t      alu2_bypass_i,
    input  logic                pass_alu1_op1_i,
    input  logic                pass_alu2_op1_i,
    input  logic                pass_alu1_op2_i,
    input  logic                pass_alu2_op2_i,
    input  logic                int_assert_i,
    output logic                div_stall_o,
    input  logic                wb_ready_i,
    output logic                reg_we_o,
    output div_pkg::reg_addr_t  reg_waddr_o,
    output div_pkg::data_t      reg_wdata_o,
    output div_pkg::commit_id_t commit_id_o
);

    import div_pkg::*;

    // request presented to both dividers
    data_t      dividend;
    data_t      divisor;
    div_op_t    op;
    reg_addr_t  waddr;
    commit_id_t cid;
    logic       start0;
    logic       start1;

    // divider status and results
    logic  div0_busy;
    logic  div0_valid;
    logic  div1_busy;
    logic  div1_valid;
    data_t div0_result;
    data_t div1_result;
    logic  ready0;
    logic  ready1;

    div_issue_buf u_issue (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_div_i      (req_div_i),
        .int_assert_i   (int_assert_i),
        .reg_waddr_i    (reg_waddr_i),
        .commit_id_i    (commit_id_i),
        .op_i           ({op_remu_i, op_rem_i, op_divu_i, op_div_i}),
        .reg1_rdata_i   (reg1_rdata_i),
        .reg2_rdata_i   (reg2_rdata_i),
        .alu1_bypass_i  (alu1_bypass_i),
        .alu2_bypass_i  (alu2_bypass_i),
        .pass_alu1_op1_i(pass_alu1_op1_i),
        .pass_alu2_op1_i(pass_alu2_op1_i),
        .pass_alu1_op2_i(pass_alu1_op2_i),
        .pass_alu2_op2_i(pass_alu2_op2_i),
        .div0_busy_i    (div0_busy),
        .div0_valid_i   (div0_valid),
        .div1_busy_i    (div1_busy),
        .div1_valid_i   (div1_valid),
        .dividend_o     (dividend),
        .divisor_o      (divisor),
        .op_o           (op),
        .waddr_o        (waddr),
        .cid_o          (cid),
        .start0_o       (start0),
        .start1_o       (start1),
        .div_stall_o    (div_stall_o)
    );

    div_iter u_div0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .dividend_i  (dividend),
        .divisor_i   (divisor),
        .op_i        (op),
        .start_i     (start0),
        .ctrl_ready_i(ready0),
        .result_o    (div0_result),
        .busy_o      (div0_busy),
        .valid_o     (div0_valid)
    );

    div_iter u_div1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .dividend_i  (dividend),
        .divisor_i   (divisor),
        .op_i        (op),
        .start_i     (start1),
        .ctrl_ready_i(ready1),
        .result_o    (div1_result),
        .busy_o      (div1_busy),
        .valid_o     (div1_valid)
    );

    div_wb_ctrl u_wb (
        .clk          (clk),
        .rst_n        (rst_n),
        .start0_i     (start0),
        .start1_i     (start1),
        .waddr_i      (waddr),
        .cid_i        (cid),
        .div0_valid_i (div0_valid),
        .div1_valid_i (div1_valid),
        .div0_busy_i  (div0_busy),
        .div1_busy_i  (div1_busy),
        .div0_result_i(div0_result),
        .div1_result_i(div1_result),
        .wb_ready_i   (wb_ready_i),
        .ready0_o     (ready0),
        .ready1_o     (ready1),
        .reg_we_o     (reg_we_o),
        .reg_waddr_o  (reg_waddr_o),
        .reg_wdata_o  (reg_wdata_o),
        .commit_id_o  (commit_id_o)
    );

endmodule

/* verification/exu_div_props.sv */
module exu_div_props (
    input logic                clk,
    input logic                rst_n,
    input logic                req_div_i,
    input logic                int_assert_i,
    input logic                div_stall_o,
    input div_pkg::reg_addr_t  reg_waddr_i,
    input div_pkg::commit_id_t commit_id_i,
    input logic                op_div_i,
    input logic                op_divu_i,
    input logic                op_rem_i,
    input logic                op_remu_i,
    input div_pkg::data_t      reg1_rdata_i,
    input div_pkg::data_t      reg2_rdata_i,
    input div_pkg::data_t      alu1_bypass_i,
    input div_pkg::data_t      alu2_bypass_i,
    input logic                pass_alu1_op1_i,
    input logic                pass_alu2_op1_i,
    input logic                pass_alu1_op2_i,
    input logic                pass_alu2_op2_i,
    input logic                start0,
    input logic                start1,
    input logic                wb_ready_i,
    input logic                reg_we_o,
    input div_pkg::reg_addr_t  reg_waddr_o,
    input div_pkg::data_t      reg_wdata_o,
    input div_pkg::commit_id_t commit_id_o
);

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    localparam int NUM_CID = 2 ** COMMIT_ID_W;

    logic        req_live;
    logic        accepted;
    logic        xfer;
    data_t       op1;
    data_t       op2;
    div_op_t     op_vec;

    // reference entries per commit ID
    logic        pend [NUM_CID];
    data_t       exp_data [NUM_CID];
    reg_addr_t   exp_waddr [NUM_CID];
    int unsigned seq_num [NUM_CID];
    int unsigned seq_next;

    // entry of the commit ID now on the write-back port
    logic        pend_now;
    data_t       exp_now;
    reg_addr_t   exp_waddr_now;

    int pend_cnt;
    int acc_cnt;
    int wb_cnt;
    int err_cnt = 0;

    // RISC-V results with the divide by zero and signed overflow cases
    function automatic data_t ref_result(div_op_t op, data_t a, data_t b);
        logic  zero;
        logic  ovf;
        data_t res;
        zero = (b == '0);
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        if (op[OP_DIV]) begin
            res = zero ? 32'hffff_ffff : ovf ? a : data_t'($signed(a) / $signed(b));
        end else if (op[OP_REM]) begin
            res = zero ? a : ovf ? 32'h0 : data_t'($signed(a) % $signed(b));
        end else if (op[OP_DIVU]) begin
            res = zero ? 32'hffff_ffff : a / b;
        end else begin
            res = zero ? a : a % b;
        end
        return res;
    endfunction

    // an older pending write to the same register
    function automatic logic older_pending(commit_id_t c);
        logic       found;
        commit_id_t k;
        found = 1'b0;
        for (int i = 0; i < NUM_CID; i++) begin
            k = commit_id_t'(i);
            if (pend[k] && (k != c) && (exp_waddr[k] == exp_waddr[c])
                && (seq_num[k] < seq_num[c])) begin
                found = 1'b1;
            end
        end
        return found;
    endfunction

    assign req_live = req_div_i && !int_assert_i;
    assign accepted = req_live && !div_stall_o;
    assign xfer     = reg_we_o && wb_ready_i;
    assign op_vec   = {op_remu_i, op_rem_i, op_divu_i, op_div_i};

    // ALU1 bypass first, then ALU2, then the register file
    assign op1 = pass_alu1_op1_i ? alu1_bypass_i :
                 pass_alu2_op1_i ? alu2_bypass_i : reg1_rdata_i;
    assign op2 = pass_alu1_op2_i ? alu1_bypass_i :
                 pass_alu2_op2_i ? alu2_bypass_i : reg2_rdata_i;

    assign pend_now      = pend[commit_id_o];
    assign exp_now       = exp_data[commit_id_o];
    assign exp_waddr_now = exp_waddr[commit_id_o];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend     <= '{default: 1'b0};
            pend_cnt <= 0;
            acc_cnt  <= 0;
            wb_cnt   <= 0;
            seq_next <= 0;
        end else begin
            if (xfer) begin
                pend[commit_id_o] <= 1'b0;
                wb_cnt            <= wb_cnt + 1;
            end
            if (accepted) begin
                pend[commit_id_i]      <= 1'b1;
                exp_data[commit_id_i]  <= ref_result(op_vec, op1, op2);
                exp_waddr[commit_id_i] <= reg_waddr_i;
                seq_num[commit_id_i]   <= seq_next;
                seq_next               <= seq_next + 1;
                acc_cnt                <= acc_cnt + 1;
            end
            pend_cnt <= pend_cnt + int'(accepted) - int'(xfer);
        end
    end

    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !reg_we_o && !div_stall_o)
        else begin
            err_cnt++;
            $error("write-back or stall active during reset");
        end

    a_known_cid: assert property (@(posedge clk) disable iff (!rst_n) xfer |-> pend_now)
        else begin
            err_cnt++;
            $error("commit ID %0d written back but not pending", $sampled(commit_id_o));
        end

    a_result: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && pend_now) |-> (reg_wdata_o == exp_now))
        else begin
            err_cnt++;
            $error("ERR reg_wdata_o cid %0d got %h exp %h", $sampled(commit_id_o),
                   $sampled(reg_wdata_o), $sampled(exp_now));
        end

    a_waddr: assert property (@(posedge clk) disable iff (!rst_n)
        (xfer && pend_now) |-> (reg_waddr_o == exp_waddr_now))
        else begin
            err_cnt++;
            $error("ERR reg_waddr_o cid %0d got %h exp %h", $sampled(commit_id_o),
                   $sampled(reg_waddr_o), $sampled(exp_waddr_now));
        end

    a_order: assert property (@(posedge clk) disable iff (!rst_n)
        xfer |-> !older_pending(commit_id_o))
        else begin
            err_cnt++;
            $error("commit ID %0d overtook an older write to the same register",
                   $sampled(commit_id_o));
        end

    // a request that starts right away reaches write-back after the fixed latency
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        $past(accepted && (start0 || start1), DIV_CYCLES) |-> reg_we_o)
        else begin
            err_cnt++;
            $error("no write-back at the fixed latency after a direct start");
        end

    // two in flight fill the buffer only in the cycle after a write-back
    a_no_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (req_live && ((pend_cnt < 2) || ((pend_cnt == 2) && !$past(xfer))))
        |-> !div_stall_o)
        else begin
            err_cnt++;
            $error("stall raised while the request buffer was free");
        end

    a_full_stall: assert property (@(posedge clk) disable iff (!rst_n)
        (req_live && (pend_cnt == 3)) |-> div_stall_o)
        else begin
            err_cnt++;
            $error("no stall while both dividers and the buffer are occupied");
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (reg_we_o && !wb_ready_i) |=> reg_we_o && $stable(reg_wdata_o)
        && $stable(reg_waddr_o) && $stable(commit_id_o))
        else begin
            err_cnt++;
            $error("write-back output changed while wb_ready_i was low");
        end

endmodule

bind exu_div exu_div_props u_props (.*);

/* verification/tb_exu_div.sv */
module tb_exu_div;

    timeunit 1ns;
    timeprecision 1ps;

    import div_pkg::*;

    localparam int NUM_DIRECTED = 21;
    localparam int NUM_RANDOM   = 200;
    localparam int NUM_REQ      = NUM_DIRECTED + NUM_RANDOM;
    localparam int WD_CYCLES    = (NUM_REQ + 10) * (int'(DIV_CYCLES) + 4);

    logic       clk = 1'b0;
    logic       rst_n;
    logic       req_div_i;
    reg_addr_t  reg_waddr_i;
    commit_id_t commit_id_i;
    logic       op_div_i;
    logic       op_divu_i;
    logic       op_rem_i;
    logic       op_remu_i;
    data_t      reg1_rdata_i;
    data_t      reg2_rdata_i;
    data_t      alu1_bypass_i;
    data_t      alu2_bypass_i;
    logic       pass_alu1_op1_i;
    logic       pass_alu2_op1_i;
    logic       pass_alu1_op2_i;
    logic       pass_alu2_op2_i;
    logic       int_assert_i;
    logic       div_stall_o;
    logic       wb_ready_i = 1'b1;
    logic       reg_we_o;
    reg_addr_t  reg_waddr_o;
    data_t      reg_wdata_o;
    commit_id_t commit_id_o;

    // write-back readiness, fixed or random per cycle
    logic       bp_random = 1'b0;
    logic       wb_ready_set = 1'b1;
    commit_id_t next_cid = '0;
    int         errs;

    exu_div UUT (.*);

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (bp_random) begin
            wb_ready_i <= ($urandom % 4) != 0;
        end else begin
            wb_ready_i <= wb_ready_set;
        end
    end

    // mix of zero, minus one, most negative and ordinary values
    function automatic data_t pick_val();
        int kind;
        kind = $urandom % 8;
        case (kind)
            0: return '0;
            1: return 32'hffff_ffff;
            2: return 32'h8000_0000;
            3: return data_t'($urandom % 16);
            default: return $urandom;
        endcase
    endfunction

    // present one request, hold it while stalled
    task automatic send_req(input int op_sel, input data_t r1, input data_t r2,
                            input data_t b1, input data_t b2, input logic [3:0] pass,
                            input reg_addr_t rd, input logic irq);
        logic stalled;
        req_div_i       <= 1'b1;
        int_assert_i    <= irq;
        reg_waddr_i     <= rd;
        commit_id_i     <= next_cid;
        op_div_i        <= (op_sel == 0);
        op_divu_i       <= (op_sel == 1);
        op_rem_i        <= (op_sel == 2);
        op_remu_i       <= (op_sel == 3);
        reg1_rdata_i    <= r1;
        reg2_rdata_i    <= r2;
        alu1_bypass_i   <= b1;
        alu2_bypass_i   <= b2;
        pass_alu1_op1_i <= pass[3];
        pass_alu2_op1_i <= pass[2];
        pass_alu1_op2_i <= pass[1];
        pass_alu2_op2_i <= pass[0];
        do begin
            @(negedge clk);
            stalled = div_stall_o;
            @(posedge clk);
        end while (stalled);
        if (!irq) begin
            next_cid = next_cid + 1'b1;
        end
    endtask

    // register file operands, bypass values ignored
    task automatic run_op(input int op_sel, input data_t a, input data_t b, input reg_addr_t rd);
        send_req(op_sel, a, b, 32'hdead_beef, 32'hcafe_f00d, 4'b0000, rd, 1'b0);
    endtask

    task automatic go_idle();
        req_div_i    <= 1'b0;
        int_assert_i <= 1'b0;
    endtask

    task automatic drain_results();
        go_idle();
        do begin
            @(negedge clk);
        end while (UUT.u_props.pend_cnt != 0);
        @(posedge clk);
    endtask

    initial begin
        void'($urandom(32'h0bed_cf30));
        rst_n           = 1'b0;
        req_div_i       = 1'b0;
        reg_waddr_i     = '0;
        commit_id_i     = '0;
        op_div_i        = 1'b0;
        op_divu_i       = 1'b0;
        op_rem_i        = 1'b0;
        op_remu_i       = 1'b0;
        reg1_rdata_i    = '0;
        reg2_rdata_i    = '0;
        alu1_bypass_i   = '0;
        alu2_bypass_i   = '0;
        pass_alu1_op1_i = 1'b0;
        pass_alu2_op1_i = 1'b0;
        pass_alu1_op2_i = 1'b0;
        pass_alu2_op2_i = 1'b0;
        int_assert_i    = 1'b0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // lone divide on an idle unit
        run_op(0, 32'd100, 32'd7, 5'd1);
        drain_results();
        // negative dividend through all four ops
        for (int op = 0; op < 4; op++) begin
            run_op(op, 32'hffff_ff9c, 32'd7, reg_addr_t'(op + 2));
        end
        drain_results();
        // zero divisor
        for (int op = 0; op < 4; op++) begin
            run_op(op, 32'h0000_1234, 32'h0, 5'd6);
        end
        drain_results();
        // most negative over minus one
        run_op(0, 32'h8000_0000, 32'hffff_ffff, 5'd7);
        run_op(2, 32'h8000_0000, 32'hffff_ffff, 5'd7);
        run_op(1, 32'h8000_0000, 32'hffff_ffff, 5'd7);
        drain_results();
        // op1 from ALU1 over ALU2, op2 from ALU2
        send_req(0, 32'd11, 32'd3, 32'd1000, 32'd5, 4'b1101, 5'd8, 1'b0);
        // cancelled by the interrupt line
        send_req(1, 32'd50, 32'd5, 32'd0, 32'd0, 4'b0000, 5'd9, 1'b1);
        drain_results();
        // four back to back, third one buffered, fourth one stalls
        run_op(0, 32'd1000, 32'd3, 5'd10);
        run_op(2, 32'd1001, 32'd3, 5'd10);
        run_op(1, 32'd999, 32'd4, 5'd11);
        run_op(3, 32'd77, 32'd5, 5'd12);
        drain_results();
        // results held under back-pressure
        wb_ready_set <= 1'b0;
        run_op(0, 32'd500, 32'd9, 5'd13);
        run_op(1, 32'd600, 32'd8, 5'd13);
        run_op(2, 32'd700, 32'd6, 5'd14);
        go_idle();
        repeat (80) @(posedge clk);
        wb_ready_set <= 1'b1;
        drain_results();

        bp_random <= 1'b1;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_req(int'($urandom % 4), pick_val(), pick_val(), pick_val(), pick_val(),
                     4'($urandom), reg_addr_t'($urandom % 4), ($urandom % 8) == 0);
            if (($urandom % 4) == 0) begin
                go_idle();
                repeat ($urandom % 3) @(posedge clk);
            end
        end
        bp_random <= 1'b0;
        drain_results();

        repeat (4) @(posedge clk);
        errs = UUT.u_props.err_cnt;
        $display("accepted %0d, written back %0d, errors %0d",
                 UUT.u_props.acc_cnt, UUT.u_props.wb_cnt, errs);
        if (errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (WD_CYCLES) @(posedge clk);
        $display("timeout: requests still not written back after %0d cycles", WD_CYCLES);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* all.f */
hdl/div_pkg.sv
hdl/div_iter.sv
hdl/div_issue_buf.sv
hdl/div_wb_ctrl.sv
hdl/exu_div.sv
verification/exu_div_props.sv
verification/tb_exu_div.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_exu_div -f all.f -o sim_exu_div
./obj_dir/sim_exu_div +verilator+error+limit+100000 > sim.log 2>&1
cat sim.log
if grep -q "^ALL CHECKS PASSED$" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
